// File: common/fetch_pkg.sv
package fetch_pkg;

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;

    // cycles from address acceptance to data_ok
    localparam int INST_LAT = 2;
    localparam int LAT_W = $clog2(INST_LAT + 1);

    localparam int IRAM_WORDS = 256;
    localparam int IRAM_AW = $clog2(IRAM_WORDS);

    localparam int FQ_DEPTH = 4;
    localparam int FQ_PTR_W = $clog2(FQ_DEPTH);
    localparam int FQ_CNT_W = $clog2(FQ_DEPTH + 1);

    localparam logic [15:0] ECODE_ADEF = 16'h4000;  // address fetch error

    // branch redirect, also reused for the buffered redirects in the fetch stage
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    // one fetched instruction on its way to decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        excp;
        logic [15:0] excp_num;
    } fs_to_ds_t;

    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } iram_req_t;

    // preload write into the instruction RAM
    typedef struct packed {
        logic               en;
        logic [IRAM_AW-1:0] idx;
        logic [31:0]        data;
    } iram_load_t;

endpackage

// File: if_stage/if_stage.sv
`timescale 1ns/10ps

module if_stage import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        ds_allowin,
    output logic        fs_valid_out,
    output fs_to_ds_t   fs_rec,
    input  br_bus_t     br,
    input  logic        excp_flush,
    input  logic        ertn_flush,
    input  logic [31:0] eentry,
    input  logic [31:0] era,
    output iram_req_t   mem_req,
    input  logic        addr_ok,
    input  logic        data_ok,
    input  logic [31:0] rdata,
    output logic        redirect
);

    logic        br_flush;
    logic        fs_flush;

    br_bus_t     excp_buf;
    br_bus_t     ertn_buf;
    br_bus_t     br_buf;

    logic [31:0] seq_pc;
    logic [31:0] nextpc;
    logic        next_adef;
    logic        fetch_go;
    logic        accept;
    logic        ps_stall;
    logic        pc_take;

    logic        fs_valid;
    logic        fs_ready_go;
    logic        fs_allowin;
    logic [31:0] fs_pc;
    logic        fs_adef;
    logic [31:0] inst_buf;
    logic        inst_buf_v;

    logic        outstanding;
    logic        discard;
    logic        halt;

    // pre-IF
    assign br_flush = br.taken && ds_allowin;  // branch only counts once decode can take it
    assign fs_flush = excp_flush || ertn_flush || br_flush;
    assign redirect = fs_flush;

    assign seq_pc = fs_pc + 32'h4;

    always_comb begin
        if (excp_flush) begin
            nextpc = eentry;
        end else if (excp_buf.taken) begin
            nextpc = excp_buf.target;
        end else if (ertn_flush) begin
            nextpc = era;
        end else if (ertn_buf.taken) begin
            nextpc = ertn_buf.target;
        end else if (br_flush) begin
            nextpc = br.target;
        end else if (br_buf.taken) begin
            nextpc = br_buf.target;
        end else begin
            nextpc = seq_pc;
        end
    end

    assign next_adef = nextpc[1:0] != 2'b00;

    // after an ADEF record the stage waits for a redirect
    assign fetch_go = !reset && fs_allowin && (!halt || fs_flush);
    assign mem_req.req  = fetch_go && !next_adef;   // misaligned pc never reaches memory
    assign mem_req.addr = nextpc;

    assign accept   = mem_req.req && addr_ok;
    assign ps_stall = mem_req.req && !addr_ok;
    assign pc_take  = accept || (fetch_go && next_adef);

    // hold redirects until the RAM takes the new address
    always_ff @(posedge clk) begin
        if (reset) begin
            excp_buf <= '0;
            ertn_buf <= '0;
            br_buf   <= '0;
        end else if (ps_stall) begin
            if (excp_flush) begin
                excp_buf <= '{taken: 1'b1, target: eentry};
            end
            if (ertn_flush) begin
                ertn_buf <= '{taken: 1'b1, target: era};
            end
            if (br_flush) begin
                br_buf <= '{taken: 1'b1, target: br.target};
            end
        end else if (pc_take) begin
            excp_buf.taken <= 1'b0;
            ertn_buf.taken <= 1'b0;
            br_buf.taken   <= 1'b0;
        end
    end

    // IF
    assign fs_ready_go  = !fs_flush && (fs_adef || inst_buf_v);
    assign fs_allowin   = !fs_valid || (fs_ready_go && ds_allowin) || fs_flush;
    assign fs_valid_out = fs_valid && fs_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
            fs_pc    <= RESET_PC - 32'h4;   // so the first nextpc is RESET_PC
            fs_adef  <= 1'b0;
        end else begin
            if (fs_allowin) begin
                fs_valid <= pc_take;
            end
            if (pc_take) begin
                fs_pc   <= nextpc;
                fs_adef <= next_adef;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_buf_v <= 1'b0;
        end else if (fs_allowin) begin
            inst_buf_v <= 1'b0;              // record left or was flushed
        end else if (data_ok && !discard) begin
            inst_buf_v <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_ok) begin
            inst_buf <= rdata;
        end
    end

    // a flush that overtakes an outstanding read marks its data as stale
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
            discard     <= 1'b0;
        end else begin
            if (accept) begin
                outstanding <= 1'b1;
            end else if (data_ok) begin
                outstanding <= 1'b0;
            end
            if (data_ok) begin
                discard <= 1'b0;
            end else if (fs_flush && outstanding) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            halt <= 1'b0;
        end else if (fs_flush) begin
            halt <= 1'b0;
        end else if (fs_valid_out && ds_allowin && fs_adef) begin
            halt <= 1'b1;
        end
    end

    assign fs_rec.pc       = fs_pc;
    assign fs_rec.inst     = fs_adef ? 32'h0 : inst_buf;
    assign fs_rec.excp     = fs_adef;
    assign fs_rec.excp_num = fs_adef ? ECODE_ADEF : 16'h0;

endmodule

// File: hw/inst_ram.sv
`timescale 1ns/10ps

module inst_ram import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  iram_req_t   mem_req,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata,
    input  iram_load_t  load
);

    logic [31:0]        mem [IRAM_WORDS];
    logic [IRAM_AW-1:0] rd_idx;
    logic [31:0]        rd_word;
    logic [LAT_W-1:0]   lat_cnt;
    logic               accept;

    // word index, address wraps modulo the depth
    assign rd_idx = mem_req.addr[IRAM_AW+1:2];

    // one read in flight, so busy until the counter runs out
    assign addr_ok = lat_cnt == '0;
    assign data_ok = lat_cnt == LAT_W'(1);
    assign accept  = mem_req.req && addr_ok;

    assign rdata = rd_word;

    always_ff @(posedge clk) begin
        if (load.en) begin
            mem[load.idx] <= load.data;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_word <= mem[rd_idx];   // sampled at acceptance
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lat_cnt <= '0;
        end else if (accept) begin
            lat_cnt <= LAT_W'(INST_LAT);
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

endmodule

// File: hw/fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue import fetch_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  fs_to_ds_t in_rec,
    output logic      allowin,
    input  logic      flush,
    output logic      out_valid,
    output fs_to_ds_t out_rec,
    input  logic      out_ready
);

    fs_to_ds_t           entries [FQ_DEPTH];
    logic [FQ_PTR_W-1:0] wr_ptr;
    logic [FQ_PTR_W-1:0] rd_ptr;
    logic [FQ_CNT_W-1:0] count;
    logic                push;
    logic                pop;

    assign allowin   = count != FQ_CNT_W'(FQ_DEPTH);
    assign out_valid = count != '0;
    assign out_rec   = entries[rd_ptr];

    assign push = in_valid && allowin;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_rec;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or push and pop together
            endcase
        end
    end

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  br_bus_t     br,
    input  logic        excp_flush,
    input  logic        ertn_flush,
    input  logic [31:0] eentry,
    input  logic [31:0] era,
    input  iram_load_t  load,
    output logic        out_valid,
    output fs_to_ds_t   out_rec,
    input  logic        out_ready
);

    iram_req_t   mem_req;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;

    logic        fs_valid_out;
    fs_to_ds_t   fs_rec;
    logic        q_allowin;
    logic        redirect;   // also empties the queue

    if_stage u_if_stage (
        .clk          (clk),
        .reset        (reset),
        .ds_allowin   (q_allowin),
        .fs_valid_out (fs_valid_out),
        .fs_rec       (fs_rec),
        .br           (br),
        .excp_flush   (excp_flush),
        .ertn_flush   (ertn_flush),
        .eentry       (eentry),
        .era          (era),
        .mem_req      (mem_req),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .redirect     (redirect)
    );

    inst_ram u_inst_ram (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata),
        .load    (load)
    );

    fetch_queue u_fetch_queue (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (fs_valid_out),
        .in_rec    (fs_rec),
        .allowin   (q_allowin),
        .flush     (redirect),
        .out_valid (out_valid),
        .out_rec   (out_rec),
        .out_ready (out_ready)
    );

endmodule

// File: tests/fetch_unit_properties.sv
`timescale 1ns/10ps

module fetch_unit_properties import fetch_pkg::*; (
    input logic      clk,
    input logic      reset,
    input iram_req_t mem_req,
    input logic      addr_ok,
    input logic      data_ok,
    input logic      redirect,
    input logic      out_valid,
    input logic      out_ready,
    input fs_to_ds_t out_rec
);

    int   fail_count = 0;
    logic inflight;         // a read was accepted and has not returned yet

    always_ff @(posedge clk) begin
        if (reset) begin
            inflight <= 1'b0;
        end else if (mem_req.req && addr_ok) begin
            inflight <= 1'b1;
        end else if (data_ok) begin
            inflight <= 1'b0;
        end
    end

    data_ok_has_read: assert property (@(posedge clk) disable iff (reset)
        data_ok |-> inflight)
        else begin
            $error("data_ok seen with no outstanding read");
            fail_count++;
        end

    // head of the queue holds while the consumer stalls
    out_held: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !redirect |=> out_valid && $stable(out_rec))
        else begin
            $error("out_rec changed while stalled");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk) $past(reset) |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            fail_count++;
        end

endmodule

bind fetch_unit fetch_unit_properties u_props (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .addr_ok   (addr_ok),
    .data_ok   (data_ok),
    .redirect  (redirect),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rec   (out_rec)
);

// File: tests/tb_fetch_unit.sv
`timescale 1ns/10ps

module tb_fetch_unit import fetch_pkg::*; ();

    localparam logic [31:0] SEED = 32'h9b3d_7fdd;
    localparam int N_RECORDS = 10 + 8 + 5 + 5 + 1 + 5 + 40;   // summed over all tests
    localparam int MAX_CYCLES = 200 * N_RECORDS;

    logic        clk = 1'b0;
    logic        reset;
    br_bus_t     br;
    logic        excp_flush;
    logic        ertn_flush;
    logic [31:0] eentry;
    logic [31:0] era;
    iram_load_t  load;
    logic        out_valid;
    fs_to_ds_t   out_rec;
    logic        out_ready;

    logic [31:0] lcg_state;
    logic [31:0] mem_copy [IRAM_WORDS];
    fs_to_ds_t   rx_q [$];
    logic [31:0] exp_pc;
    logic [31:0] pending_tgt;
    logic        pending;       // redirect driven and its target not seen yet
    logic        rand_ready;
    int          cycle_count = 0;

    fetch_unit DUT (
        .clk        (clk),
        .reset      (reset),
        .br         (br),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .eentry     (eentry),
        .era        (era),
        .load       (load),
        .out_valid  (out_valid),
        .out_rec    (out_rec),
        .out_ready  (out_ready)
    );

    always #4 clk = ~clk;

    // inputs only move on posedge so the handshake is stable here
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            rx_q.push_back(out_rec);
        end
    end

    always @(negedge clk) begin
        if (DUT.u_props.fail_count != 0) begin
            $display("A protocol assertion on fetch_unit fired");
            $display("Verification failed");
            $fatal(1);
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycle_count <= cycle_count + 1;
        end
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles without the expected records", cycle_count);
            $display("Verification failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // expected inst is the preloaded word at the address taken modulo the depth
    task automatic check_record(input fs_to_ds_t rec);
        if (pending && rec.pc == pending_tgt) begin
            pending = 1'b0;
            exp_pc  = pending_tgt;
        end
        check_value("out_rec.pc", rec.pc, exp_pc);
        if (exp_pc[1:0] != 2'b00) begin
            check_value("out_rec.excp", rec.excp, 32'h1);
            check_value("out_rec.excp_num", rec.excp_num, ECODE_ADEF);
            check_value("out_rec.inst", rec.inst, 32'h0);
        end else begin
            check_value("out_rec.excp", rec.excp, 32'h0);
            check_value("out_rec.inst", rec.inst, mem_copy[(exp_pc >> 2) % IRAM_WORDS]);
        end
        exp_pc = exp_pc + 32'h4;
    endtask

    // old path records may still drain until the target shows up
    task automatic take_records(input int n);
        fs_to_ds_t   rec;
        logic [31:0] r;
        int          got;
        got = 0;
        while (got < n) begin
            if (rx_q.size() == 0) begin
                @(posedge clk);
                if (rand_ready) begin
                    r = next_rand();
                    out_ready <= r[21:20] == 2'b00;   // ready one cycle in four so the queue fills
                end
            end else begin
                rec = rx_q.pop_front();
                check_record(rec);
                if (!pending) begin
                    got++;
                end
            end
        end
    endtask

    task automatic pulse_redirect(input logic excp, input logic [31:0] entry,
                                  input logic ertn, input logic [31:0] ret,
                                  input br_bus_t b);
        @(posedge clk);
        excp_flush <= excp;
        ertn_flush <= ertn;
        eentry     <= entry;
        era        <= ret;
        br         <= b;
        @(posedge clk);
        excp_flush <= 1'b0;
        ertn_flush <= 1'b0;
        br         <= '0;
    endtask

    task automatic preload_ram();
        logic [31:0] word;
        for (int i = 0; i < IRAM_WORDS; i++) begin
            word = next_rand();
            mem_copy[i] = word;
            @(posedge clk);
            load <= '{en: 1'b1, idx: IRAM_AW'(i), data: word};
        end
        @(posedge clk);
        load <= '0;
    endtask

    task automatic sequential_fetch();
        exp_pc  = RESET_PC;
        pending = 1'b0;
        take_records(10);
    endtask

    task automatic branch_redirect();
        pending_tgt = 32'h1c00_0340;
        pending     = 1'b1;
        pulse_redirect(1'b0, 32'h0, 1'b0, 32'h0, '{taken: 1'b1, target: pending_tgt});
        take_records(8);
    endtask

    task automatic flush_priority();
        pending_tgt = 32'h1c00_0600;     // eentry beats era and the branch
        pending     = 1'b1;
        pulse_redirect(1'b1, 32'h1c00_0600, 1'b1, 32'h1c00_0200,
                       '{taken: 1'b1, target: 32'h1c00_0700});
        take_records(5);
        pending_tgt = 32'h1c00_0200;
        pending     = 1'b1;
        pulse_redirect(1'b0, 32'h1c00_0600, 1'b1, 32'h1c00_0200, '0);
        take_records(5);
    endtask

    task automatic address_error();
        pending_tgt = 32'h1c00_0502;
        pending     = 1'b1;
        pulse_redirect(1'b0, 32'h0, 1'b0, 32'h0, '{taken: 1'b1, target: pending_tgt});
        take_records(1);
        pending_tgt = 32'h1c00_0080;
        pending     = 1'b1;
        pulse_redirect(1'b1, 32'h1c00_0080, 1'b0, 32'h0, '0);
        take_records(5);
    endtask

    task automatic back_pressure();
        rand_ready = 1'b1;
        take_records(40);
        rand_ready = 1'b0;
        @(posedge clk);
        out_ready <= 1'b1;
    endtask

    initial begin
        reset      = 1'b1;
        br         = '0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
        eentry     = 32'h0;
        era        = 32'h0;
        load       = '0;
        out_ready  = 1'b1;
        rand_ready = 1'b0;
        pending    = 1'b0;
        lcg_state  = SEED;

        preload_ram();              // reset stays high through the preload
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        sequential_fetch();
        branch_redirect();
        flush_priority();
        address_error();
        back_pressure();

        repeat (4) @(posedge clk);
        if (DUT.u_props.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1);
        end
    end

endmodule

// File: sim.f
common/fetch_pkg.sv
if_stage/if_stage.sv
hw/inst_ram.sv
hw/fetch_queue.sv
hw/fetch_unit.sv
tests/fetch_unit_properties.sv
tests/tb_fetch_unit.sv
